//--- include/hyp_cfg.svh
/*
  Fixed-point format and register map of the hyperbolic unit.
  The Q16.16 format is fixed; the exp engine constants assume 16 fraction
  bits and a 32-bit word, so changing these values alone is not supported.
*/
`ifndef HYP_CFG_SVH
`define HYP_CFG_SVH

// Data word and fraction width, Q16.16
`define HYP_DATA_W 32
`define HYP_FRAC_W 16

// Shift-add steps of the exp engine
`define HYP_EXP_ITERS 15

// Register addresses on the 1-bit cfg_addr
`define HYP_ADDR_MODE   1'b0
`define HYP_ADDR_STATUS 1'b1

`endif

//--- run.sh
#!/bin/sh
# Build and run the hyperbolic unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module hyperbolic_unit_tb \
    -o hyperbolic_unit_sim \
  && ./obj_dir/hyperbolic_unit_sim | tee /dev/stderr | grep -qx '\*\* PASS \*\*' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- src/hyp_config_regs.sv
/*
  Mode register and sticky overflow status of the hyperbolic unit.
  Writes of the illegal mode code 3 are dropped. A status write clears
  the sticky bit unless an overflow pulse arrives in the same cycle.
*/
`default_nettype none
`timescale 1ns/1ps

`include "hyp_cfg.svh"

module hyp_config_regs (
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire logic                   cfg_we,
  input  wire logic                   cfg_addr,
  input  wire logic [`HYP_DATA_W-1:0] cfg_wdata,
  input  wire logic                   ovf_pulse,
  output logic      [`HYP_DATA_W-1:0] cfg_rdata,
  output hyp_pkg::hyp_mode_e          mode
);

  logic sticky_q;

  // Mode register, resets to cosh
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mode <= hyp_pkg::HYP_COSH;
    end else if (cfg_we && cfg_addr == `HYP_ADDR_MODE && cfg_wdata[1:0] != 2'b11) begin
      mode <= hyp_pkg::hyp_mode_e'(cfg_wdata[1:0]);
    end
  end

  // Sticky overflow, set has priority over the clearing write
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sticky_q <= 1'b0;
    end else if (ovf_pulse) begin
      sticky_q <= 1'b1;
    end else if (cfg_we && cfg_addr == `HYP_ADDR_STATUS) begin
      sticky_q <= 1'b0;
    end
  end

  // Read-back of the addressed register
  always_comb begin
    if (cfg_addr == `HYP_ADDR_MODE) begin
      cfg_rdata = {{(`HYP_DATA_W-2){1'b0}}, mode};
    end else begin
      cfg_rdata = {{(`HYP_DATA_W-1){1'b0}}, sticky_q};
    end
  end

  // The sequencer decodes only the three legal codes
  a_mode_legal: assert property (@(posedge CLK) disable iff (RST)
    mode != 2'b11);

endmodule

`default_nettype wire

//--- src/hyp_pkg.sv
/*
  Types shared by the hyperbolic unit and its testbench.
  fix_t is a signed Q16.16 word. Mode code 3 is illegal and never held.
*/
`default_nettype none

`include "hyp_cfg.svh"

package hyp_pkg;

  // Signed Q16.16 fixed-point word
  typedef logic signed [`HYP_DATA_W-1:0] fix_t;

  // Saturation limits of fix_t
  localparam fix_t FIX_MAX = {1'b0, {(`HYP_DATA_W-1){1'b1}}};
  localparam fix_t FIX_MIN = {1'b1, {(`HYP_DATA_W-1){1'b0}}};

  // Function select, code 3 unused
  typedef enum logic [1:0] {
    HYP_EXP  = 2'd0,
    HYP_COSH = 2'd1,
    HYP_SINH = 2'd2
  } hyp_mode_e;

endpackage

`default_nettype wire

//--- src/hyperbolic_unit.sv
/*
  Hyperbolic function unit top level, configuration block and sequencer.
  Overflow sets the sticky status only in the cycle of its ready pulse.
*/
`default_nettype none
`timescale 1ns/1ps

`include "hyp_cfg.svh"

module hyperbolic_unit (
  input  wire logic                   CLK,
  input  wire logic                   RST,

  // Configuration port
  input  wire logic                   cfg_we,
  input  wire logic                   cfg_addr,
  input  wire logic [`HYP_DATA_W-1:0] cfg_wdata,
  output logic      [`HYP_DATA_W-1:0] cfg_rdata,

  // Function port
  input  wire logic                   start,
  input  wire hyp_pkg::fix_t          data_in,
  output logic                        ready,
  output hyp_pkg::fix_t               data_out,
  output logic                        overflow
);

  // Function select from the mode register
  hyp_pkg::hyp_mode_e mode;

  hyp_config_regs i_hyp_config_regs (
    .CLK       (CLK),
    .RST       (RST),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .ovf_pulse (overflow & ready),
    .cfg_rdata (cfg_rdata),
    .mode      (mode)
  );

  scalar_hyperbolic_function i_scalar_hyperbolic_function (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .data_in  (data_in),
    .mode     (mode),
    .ready    (ready),
    .data_out (data_out),
    .overflow (overflow)
  );

endmodule

`default_nettype wire

//--- src/scalar_exp_iterative.sv
/*
  Iterative e^x on a signed Q16.16 operand, one request at a time.
  exp_done follows the accepted exp_start after exactly 17 cycles.
  Results of 2^15 and above saturate to the largest value with exp_ovf set.
  Small results truncate toward zero; the relative error stays below 2^-14.
*/
`default_nettype none
`timescale 1ns/1ps

`include "hyp_cfg.svh"

module scalar_exp_iterative (
  input  wire logic         CLK,
  input  wire logic         RST,
  input  wire logic         exp_start,
  input  wire hyp_pkg::fix_t exp_arg,
  output logic              exp_done,
  output hyp_pkg::fix_t     exp_result,
  output logic              exp_ovf
);

  ////////////////////////////////////////////////////////////////////////////
  // Constants

  // Internal fraction bits of r and y
  localparam int Q_FRAC    = 30;
  localparam int ARG_SHIFT = Q_FRAC - `HYP_FRAC_W;
  // k field of the x/ln2 product, and wide range-reduction word
  localparam int K_POS = `HYP_FRAC_W + Q_FRAC;
  localparam int K_W   = 18;
  localparam int W_W   = 50;

  localparam logic signed [`HYP_DATA_W-1:0] INV_LN2_Q30 = 32'sd1549082005;
  localparam logic signed [W_W-1:0]         LN2_Q30     = 50'sd744261118;
  localparam logic [`HYP_DATA_W-1:0]        ONE_Q30     = 32'h4000_0000;

  typedef enum logic [1:0] {E_IDLE, E_ITER, E_SHIFT} exp_state_e;

  // ln(1 + 2^-i) in Q2.30
  function automatic logic [`HYP_DATA_W-1:0] ln_tab(input logic [4:0] idx);
    case (idx)
      5'd1:    ln_tab = 32'd435364845;
      5'd2:    ln_tab = 32'd239598564;
      5'd3:    ln_tab = 32'd126468572;
      5'd4:    ln_tab = 32'd65095192;
      5'd5:    ln_tab = 32'd33040817;
      5'd6:    ln_tab = 32'd16647494;
      5'd7:    ln_tab = 32'd8356009;
      5'd8:    ln_tab = 32'd4186133;
      5'd9:    ln_tab = 32'd2095107;
      5'd10:   ln_tab = 32'd1048064;
      5'd11:   ln_tab = 32'd524160;
      5'd12:   ln_tab = 32'd262112;
      5'd13:   ln_tab = 32'd131064;
      5'd14:   ln_tab = 32'd65534;
      5'd15:   ln_tab = 32'd32767;
      default: ln_tab = '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Signals

  exp_state_e                state;
  logic [4:0]                step_q;
  logic signed [K_W-1:0]     k_q;
  logic [`HYP_DATA_W-1:0]    r_q;
  logic [`HYP_DATA_W-1:0]    y_q;

  logic signed [63:0]        prod;
  logic signed [K_W-1:0]     k_calc;
  logic signed [W_W-1:0]     x_wide;
  logic signed [W_W-1:0]     k_wide;
  logic signed [W_W-1:0]     r_wide;
  logic [`HYP_DATA_W-1:0]    r_red;
  logic signed [K_W:0]       shift_amt;
  hyp_pkg::fix_t             shift_val;

  ////////////////////////////////////////////////////////////////////////////
  // Range reduction and final shift

  always_comb begin
    // k = floor(x / ln2), taken from the upper product bits
    prod   = 64'(exp_arg) * 64'(INV_LN2_Q30);
    k_calc = prod[K_POS +: K_W];
    x_wide = W_W'(exp_arg);
    k_wide = W_W'(k_calc);
    // r = x - k*ln2 in Q.30
    r_wide = (x_wide <<< ARG_SHIFT) - k_wide * LN2_Q30;
    // Rounding of 1/ln2 can push r just outside [0, ln2)
    if (r_wide[W_W-1]) begin
      r_red = '0;
    end else if (r_wide >= LN2_Q30) begin
      r_red = LN2_Q30[`HYP_DATA_W-1:0] - 32'd1;
    end else begin
      r_red = r_wide[`HYP_DATA_W-1:0];
    end

    // Scale y by 2^k and drop back to Q16.16, negative amount is overflow
    shift_amt = (K_W+1)'(ARG_SHIFT) - k_q;
    if (shift_amt[K_W]) begin
      shift_val = hyp_pkg::FIX_MAX;
    end else if (|shift_amt[K_W-1:5]) begin
      shift_val = '0;
    end else begin
      shift_val = y_q >> shift_amt[4:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= E_IDLE;
      step_q   <= '0;
      exp_done <= 1'b0;
      exp_ovf  <= 1'b0;
    end else begin
      exp_done <= 1'b0;
      case (state)
        E_IDLE: begin
          if (exp_start) begin
            step_q <= 5'd1;
            state  <= E_ITER;
          end
        end
        E_ITER: begin
          if (step_q == 5'(`HYP_EXP_ITERS)) begin
            step_q <= '0;
            state  <= E_SHIFT;
          end else begin
            step_q <= step_q + 5'd1;
          end
        end
        E_SHIFT: begin
          exp_ovf  <= shift_amt[K_W];
          exp_done <= 1'b1;
          state    <= E_IDLE;
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state == E_IDLE && exp_start) begin
      k_q <= k_calc;
      r_q <= r_red;
      y_q <= ONE_Q30;
    end else if (state == E_ITER && r_q >= ln_tab(step_q)) begin
      // Greedy step, y *= 1 + 2^-i
      r_q <= r_q - ln_tab(step_q);
      y_q <= y_q + (y_q >> step_q);
    end
    if (state == E_SHIFT) begin
      exp_result <= shift_val;
    end
  end

  a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
    exp_done |=> !exp_done);

  a_step_range: assert property (@(posedge CLK) disable iff (RST)
    step_q <= 5'(`HYP_EXP_ITERS));

endmodule

`default_nettype wire

//--- src/scalar_hyperbolic_function.sv
/*
  Runs the exp engine once for exp, twice for cosh and sinh.
  start counts only while idle; ready pulses 19 or 37 cycles later.
  data_out and overflow hold until the next result.
*/
`default_nettype none
`timescale 1ns/1ps

`include "hyp_cfg.svh"

module scalar_hyperbolic_function (
  input  wire logic               CLK,
  input  wire logic               RST,
  input  wire logic               start,
  input  wire hyp_pkg::fix_t      data_in,
  input  wire hyp_pkg::hyp_mode_e mode,
  output logic                    ready,
  output hyp_pkg::fix_t           data_out,
  output logic                    overflow
);

  localparam int EW = `HYP_DATA_W + 2;
  // ln2 in Q16.16, an argument offset that halves e^x
  localparam logic signed [EW-1:0] LN2_FIX = 34'sd45426;
  localparam logic signed [EW-1:0] EXT_MAX = EW'(hyp_pkg::FIX_MAX);
  localparam logic signed [EW-1:0] EXT_MIN = EW'(hyp_pkg::FIX_MIN);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN_POS, ST_RUN_NEG, ST_COMBINE} seq_state_e;

  function automatic hyp_pkg::fix_t sat_arg(input logic signed [EW-1:0] v);
    if (v > EXT_MAX) begin
      sat_arg = hyp_pkg::FIX_MAX;
    end else if (v < EXT_MIN) begin
      sat_arg = hyp_pkg::FIX_MIN;
    end else begin
      sat_arg = v[`HYP_DATA_W-1:0];
    end
  endfunction

  seq_state_e                    state;
  hyp_pkg::hyp_mode_e            mode_q;
  logic                          launch_q;
  hyp_pkg::fix_t                 pos_arg_q, neg_arg_q, pos_q, neg_q;
  logic                          pos_ovf_q, neg_ovf_q, arg_neg_q;
  logic signed [EW-1:0]          x_ext;
  hyp_pkg::fix_t                 pos_arg_c, neg_arg_c, comb_val;
  logic signed [`HYP_DATA_W:0]   sum_w, dif_w;
  logic                          comb_ovf;
  logic                          exp_start, exp_done, exp_ovf;
  hyp_pkg::fix_t                 exp_arg, exp_result;

  // First run on the latched argument, second one launched on exp_done
  assign exp_start = launch_q | (state == ST_RUN_POS && exp_done && mode_q != hyp_pkg::HYP_EXP);
  assign exp_arg   = launch_q ? pos_arg_q : neg_arg_q;

  scalar_exp_iterative i_scalar_exp_iterative (
    .CLK        (CLK),
    .RST        (RST),
    .exp_start  (exp_start),
    .exp_arg    (exp_arg),
    .exp_done   (exp_done),
    .exp_result (exp_result),
    .exp_ovf    (exp_ovf)
  );

  always_comb begin
    // Runs of cosh and sinh return e^x/2 and e^-x/2
    x_ext     = EW'(data_in);
    pos_arg_c = (mode == hyp_pkg::HYP_EXP) ? data_in : sat_arg(x_ext - LN2_FIX);
    neg_arg_c = sat_arg(-x_ext - LN2_FIX);
    sum_w     = (`HYP_DATA_W+1)'(pos_q) + (`HYP_DATA_W+1)'(neg_q);
    dif_w     = (`HYP_DATA_W+1)'(pos_q) - (`HYP_DATA_W+1)'(neg_q);
    if (mode_q == hyp_pkg::HYP_SINH) begin
      comb_ovf = pos_ovf_q | neg_ovf_q | (dif_w[`HYP_DATA_W] != dif_w[`HYP_DATA_W-1]);
    end else begin
      comb_ovf = pos_ovf_q | neg_ovf_q | (sum_w[`HYP_DATA_W] != sum_w[`HYP_DATA_W-1]);
    end
    // Saturate, sinh keeps the operand sign
    if (comb_ovf) begin
      comb_val = (mode_q == hyp_pkg::HYP_SINH && arg_neg_q) ? hyp_pkg::FIX_MIN : hyp_pkg::FIX_MAX;
    end else if (mode_q == hyp_pkg::HYP_SINH) begin
      comb_val = dif_w[`HYP_DATA_W-1:0];
    end else begin
      comb_val = sum_w[`HYP_DATA_W-1:0];
    end
  end

  // FSM and result outputs
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ST_IDLE;
      mode_q   <= hyp_pkg::HYP_COSH;
      launch_q <= 1'b0;
      ready    <= 1'b0;
      overflow <= 1'b0;
      data_out <= '0;
    end else begin
      ready    <= 1'b0;
      launch_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            mode_q   <= mode;
            launch_q <= 1'b1;
            state    <= ST_RUN_POS;
          end
        end
        ST_RUN_POS: begin
          if (exp_done && mode_q == hyp_pkg::HYP_EXP) begin
            data_out <= exp_result;
            overflow <= exp_ovf;
            ready    <= 1'b1;
            state    <= ST_IDLE;
          end else if (exp_done) begin
            state <= ST_RUN_NEG;
          end
        end
        ST_RUN_NEG: begin
          if (exp_done) begin
            state <= ST_COMBINE;
          end
        end
        ST_COMBINE: begin
          data_out <= comb_val;
          overflow <= comb_ovf;
          ready    <= 1'b1;
          state    <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Arguments and partial results
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && start) begin
      pos_arg_q <= pos_arg_c;
      neg_arg_q <= neg_arg_c;
      arg_neg_q <= data_in[`HYP_DATA_W-1];
    end
    if (state == ST_RUN_POS && exp_done) begin
      pos_q     <= exp_result;
      pos_ovf_q <= exp_ovf;
    end
    if (state == ST_RUN_NEG && exp_done) begin
      neg_q     <= exp_result;
      neg_ovf_q <= exp_ovf;
    end
  end

  a_ready_src: assert property (@(posedge CLK) disable iff (RST)
    $rose(ready) |-> ($past(state) == ST_COMBINE) ||
      ($past(state) == ST_RUN_POS && $past(mode_q) == hyp_pkg::HYP_EXP));

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
src/hyp_pkg.sv
src/hyp_config_regs.sv
src/scalar_exp_iterative.sv
src/scalar_hyperbolic_function.sv
src/hyperbolic_unit.sv
verif/hyperbolic_unit_tb.sv

//--- verif/hyperbolic_unit_tb.sv
/*
  Randomized testbench of the hyperbolic unit against a real-valued model.
  Results pass within 2^-12 relative error or 8 LSB of the model.
  Random operands keep 0.01 away from the overflow boundaries.
  The run stops at the first mismatch or timeout.
*/
`default_nettype none
`timescale 1ns/1ps

`include "hyp_cfg.svh"

module hyperbolic_unit_tb;

  // Cycles allowed for one request, and quiet cycles after a busy start
  localparam int READY_TIMEOUT = 200;
  localparam int QUIET_WINDOW  = 80;
  // Saturation values of Q16.16
  localparam logic [31:0] SAT_POS = 32'h7fff_ffff;
  localparam logic [31:0] SAT_NEG = 32'h8000_0000;
  localparam real         ONE_FIX = 65536.0;
  localparam int          RANGE_MAX = 20 * 65536;

  logic          CLK;
  logic          RST;
  logic          cfg_we;
  logic          cfg_addr;
  logic [31:0]   cfg_wdata;
  logic [31:0]   cfg_rdata;
  logic          start;
  hyp_pkg::fix_t data_in;
  logic          ready;
  hyp_pkg::fix_t data_out;
  logic          overflow;

  // Operand limits in LSB, set at the start of the run
  int            exp_safe;
  int            exp_over;
  int            hyp_safe;
  int            hyp_over;
  hyp_pkg::fix_t x;
  hyp_pkg::fix_t x2;
  hyp_pkg::fix_t res;
  logic          ovf;
  logic [31:0]   rdata;
  logic [31:0]   mode_before;

  hyperbolic_unit i_hyperbolic_unit (
    .CLK       (CLK),
    .RST       (RST),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .start     (start),
    .data_in   (data_in),
    .ready     (ready),
    .data_out  (data_out),
    .overflow  (overflow)
  );

  // 100 ns clock
  always #50 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Reporting

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  // Signed distance of two words against an LSB tolerance
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected, input int tol);
    longint diff;
    diff = longint'($signed(got)) - longint'($signed(expected));
    if (diff < 0) begin
      diff = -diff;
    end
    if (diff > longint'(tol)) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
      $display("** FAIL **");
      $fatal(1, "simulation stopped");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and request drivers

  task automatic write_reg(input logic addr, input logic [31:0] data);
    @(posedge CLK);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge CLK);
    cfg_we    <= 1'b0;
  endtask

  // Read-back is combinational, sampled mid-cycle
  task automatic read_reg(input logic addr, output logic [31:0] data);
    @(posedge CLK);
    cfg_addr <= addr;
    @(negedge CLK);
    data = cfg_rdata;
  endtask

  task automatic pulse_start(input hyp_pkg::fix_t v);
    @(posedge CLK);
    start   <= 1'b1;
    data_in <= v;
    @(posedge CLK);
    start   <= 1'b0;
  endtask

  task automatic wait_ready(input string what, input hyp_pkg::fix_t v);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!ready) begin
      if (cycles == READY_TIMEOUT) begin
        stop_run($sformatf("Timeout: %s request with operand 0x%08h never completed",
                           what, v));
      end
      cycles++;
      @(negedge CLK);
    end
  endtask

  task automatic run_request(input hyp_pkg::hyp_mode_e m, input hyp_pkg::fix_t v,
                             output hyp_pkg::fix_t r, output logic o);
    pulse_start(v);
    wait_ready(m.name(), v);
    r = data_out;
    o = overflow;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks

  function automatic real model_result(input hyp_pkg::hyp_mode_e m,
                                       input hyp_pkg::fix_t v);
    real xr;
    xr = $itor(v) / ONE_FIX;
    case (m)
      hyp_pkg::HYP_EXP:  model_result = $exp(xr);
      hyp_pkg::HYP_SINH: model_result = ($exp(xr) - $exp(-xr)) / 2.0;
      default:           model_result = ($exp(xr) + $exp(-xr)) / 2.0;
    endcase
  endfunction

  // Uniform operand in [lo, hi], in LSB
  function automatic hyp_pkg::fix_t rand_operand(input int lo, input int hi);
    int unsigned span;
    span = unsigned'(hi - lo) + 32'd1;
    rand_operand = hyp_pkg::fix_t'(lo + int'($urandom % span));
  endfunction

  task automatic check_result(input hyp_pkg::hyp_mode_e m, input hyp_pkg::fix_t v,
                              input hyp_pkg::fix_t r, input logic o);
    int expected;
    int mag;
    int tol;
    // Model value truncated toward zero like the Q16.16 output
    expected = $rtoi(model_result(m, v) * ONE_FIX);
    mag      = (expected < 0) ? -expected : expected;
    tol      = mag >>> 12;
    if (tol < 8) begin
      tol = 8;
    end
    check_value("data_out", r, expected, tol);
    check_value("overflow", {31'b0, o}, 32'd0, 0);
    // sinh keeps the operand sign, away from zero
    if (m == hyp_pkg::HYP_SINH && (v > 256 || v < -256)) begin
      check_value("data_out sign", {31'b0, r[31]}, {31'b0, v[31]}, 0);
    end
  endtask

  task automatic run_random_batch(input hyp_pkg::hyp_mode_e m, input int lo,
                                  input int hi, input int count);
    hyp_pkg::fix_t v;
    hyp_pkg::fix_t r;
    logic          o;
    for (int n = 0; n < count; n++) begin
      v = rand_operand(lo, hi);
      run_request(m, v, r, o);
      check_result(m, v, r, o);
    end
  endtask

  // Saturation: largest value, most negative for sinh of a negative operand
  task automatic run_overflow_batch(input hyp_pkg::hyp_mode_e m, input int lo,
                                    input int count, input logic both_signs);
    hyp_pkg::fix_t v;
    hyp_pkg::fix_t r;
    logic          o;
    logic [31:0]   sat;
    for (int n = 0; n < count; n++) begin
      v = rand_operand(lo, RANGE_MAX);
      if (both_signs && ($urandom % 32'd2) == 32'd1) begin
        v = -v;
      end
      run_request(m, v, r, o);
      sat = (m == hyp_pkg::HYP_SINH && v < 0) ? SAT_NEG : SAT_POS;
      check_value("data_out", r, sat, 0);
      check_value("overflow", {31'b0, o}, 32'd1, 0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    CLK       = 1'b0;
    RST       = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    start     = 1'b0;
    data_in   = '0;
    void'($urandom(32'h1b74));
    exp_safe = $rtoi(($ln(32768.0) - 0.01) * ONE_FIX);
    exp_over = $rtoi(($ln(32768.0) + 0.01) * ONE_FIX);
    hyp_safe = $rtoi(($ln(65534.0) - 0.01) * ONE_FIX);
    hyp_over = $rtoi(($ln(65534.0) + 0.01) * ONE_FIX);

    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    // Reset values
    @(negedge CLK);
    check_value("ready", {31'b0, ready}, 32'd0, 0);
    check_value("overflow", {31'b0, overflow}, 32'd0, 0);
    check_value("data_out", data_out, 32'd0, 0);
    read_reg(`HYP_ADDR_MODE, rdata);
    check_value("mode register", rdata, {30'b0, hyp_pkg::HYP_COSH}, 0);
    read_reg(`HYP_ADDR_STATUS, rdata);
    check_value("status register", rdata, 32'd0, 0);

    // cosh is the reset mode
    run_random_batch(hyp_pkg::HYP_COSH, -10 * 65536, 10 * 65536, 200);

    write_reg(`HYP_ADDR_MODE, {30'b0, hyp_pkg::HYP_EXP});
    run_random_batch(hyp_pkg::HYP_EXP, -12 * 65536, exp_safe, 150);
    write_reg(`HYP_ADDR_MODE, {30'b0, hyp_pkg::HYP_SINH});
    run_random_batch(hyp_pkg::HYP_SINH, -hyp_safe, hyp_safe, 150);

    // Overflow of each function
    write_reg(`HYP_ADDR_MODE, {30'b0, hyp_pkg::HYP_EXP});
    run_overflow_batch(hyp_pkg::HYP_EXP, exp_over, 10, 1'b0);
    write_reg(`HYP_ADDR_MODE, {30'b0, hyp_pkg::HYP_COSH});
    run_overflow_batch(hyp_pkg::HYP_COSH, hyp_over, 10, 1'b1);
    write_reg(`HYP_ADDR_MODE, {30'b0, hyp_pkg::HYP_SINH});
    run_overflow_batch(hyp_pkg::HYP_SINH, hyp_over, 10, 1'b1);

    // Sticky status survives clean results, cleared by a write
    read_reg(`HYP_ADDR_STATUS, rdata);
    check_value("status register", rdata, 32'd1, 0);
    run_random_batch(hyp_pkg::HYP_SINH, -hyp_safe, hyp_safe, 5);
    read_reg(`HYP_ADDR_STATUS, rdata);
    check_value("status register", rdata, 32'd1, 0);
    write_reg(`HYP_ADDR_STATUS, 32'd0);
    read_reg(`HYP_ADDR_STATUS, rdata);
    check_value("status register", rdata, 32'd0, 0);

    // Clear while the overflow output is still held
    run_overflow_batch(hyp_pkg::HYP_SINH, hyp_over, 1, 1'b0);
    write_reg(`HYP_ADDR_STATUS, 32'd0);
    read_reg(`HYP_ADDR_STATUS, rdata);
    check_value("status register", rdata, 32'd0, 0);

    // Second start while busy, operands far apart so results differ
    write_reg(`HYP_ADDR_MODE, {30'b0, hyp_pkg::HYP_COSH});
    x  = rand_operand(32768, 4 * 65536);
    x2 = rand_operand(6 * 65536, 10 * 65536);
    pulse_start(x);
    repeat (4) @(posedge CLK);
    start   <= 1'b1;
    data_in <= x2;
    @(posedge CLK);
    start   <= 1'b0;
    wait_ready("COSH with a start while busy", x);
    res = data_out;
    ovf = overflow;
    check_result(hyp_pkg::HYP_COSH, x, res, ovf);
    for (int n = 0; n < QUIET_WINDOW; n++) begin
      @(negedge CLK);
      if (ready) begin
        stop_run("A start issued while busy produced a second ready pulse");
      end
    end

    // Illegal mode code leaves the register alone
    read_reg(`HYP_ADDR_MODE, mode_before);
    write_reg(`HYP_ADDR_MODE, 32'd3);
    read_reg(`HYP_ADDR_MODE, rdata);
    check_value("mode register", rdata, mode_before, 0);

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
